// File: design/xadc_adc_pkg.sv
package xadc_adc_pkg;

    // Converter word and channel select
    localparam int result_w  = 12;
    localparam int channel_w = 3;

    // Counters driven from the slow-control registers
    localparam int sample_cnt_w = 11;
    localparam int delay_w      = 18;  // Gap between conversions in clk125 cycles

    typedef logic [result_w-1:0]  adc_result_t;
    typedef logic [channel_w-1:0] adc_channel_t;

endpackage

// File: design/xadc_frame_pkg.sv
package xadc_frame_pkg;

    // Packet holds a header and five results
    localparam int packet_w         = 64;
    localparam int slots_per_packet = 5;
    localparam int header_w         = 4;   // Zero bit then channel

    // Packet goes out on a 16 bit bus
    localparam int word_w           = 16;
    localparam int words_per_packet = packet_w / word_w;

    // Running frame length in 16 bit words
    localparam int len_w = 12;

    typedef logic [word_w-1:0]   frame_word_t;
    typedef logic [len_w-1:0]    frame_len_t;
    typedef logic [packet_w-1:0] packet_t;

endpackage

// File: design/xadc_frame_writer.sv
`timescale 1ns/1ps

module xadc_frame_writer
#(
    parameter int max_frame_words = 600
)
(
    input  logic                         clk125,
    input  logic                         rst,
    input  logic                         full,
    input  logic                         flush,
    input  xadc_frame_pkg::packet_t      packet,
    input  xadc_frame_pkg::frame_len_t   frame_words,
    output xadc_frame_pkg::frame_word_t  fifo_bus,
    output logic                         data_fifo_enable,
    output xadc_frame_pkg::frame_len_t   packet_len,
    output logic                         end_of_data,
    output logic                         packet_clear,
    output logic                         frame_clear,
    output logic                         frame_done
);
    import xadc_frame_pkg::*;

    localparam int cnt_w = $clog2(words_per_packet);

    typedef enum logic [2:0] {w_idle, w_send, w_done, w_gap1, w_gap2} wr_state_t;

    wr_state_t         state;
    packet_t           shift_r;
    logic [cnt_w-1:0]  word_cnt;
    logic              flushing;   // This packet closes the channel
    logic              start;

    // Flush is held until frame_done, so its level is enough here
    assign start = full || flush;

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state            <= w_idle;
            data_fifo_enable <= 1'b0;
            end_of_data      <= 1'b0;
            packet_clear     <= 1'b0;
            frame_clear      <= 1'b0;
            frame_done       <= 1'b0;
            packet_len       <= '0;
            flushing         <= 1'b0;
            word_cnt         <= '0;
        end
        else
        begin
            packet_clear <= 1'b0;
            frame_clear  <= 1'b0;
            frame_done   <= 1'b0;
            case (state)
                w_idle:
                begin
                    if (start)
                    begin
                        data_fifo_enable <= 1'b1;
                        packet_len       <= frame_words;
                        flushing         <= flush;
                        word_cnt         <= cnt_w'(1);
                        state            <= w_send;
                    end
                end

                w_send:
                begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == cnt_w'(words_per_packet - 1))
                    begin
                        end_of_data <= (packet_len == len_w'(max_frame_words)) || flushing;
                        state       <= w_done;
                    end
                end

                w_done:
                begin
                    data_fifo_enable <= 1'b0;
                    end_of_data      <= 1'b0;
                    packet_clear     <= 1'b1;
                    frame_clear      <= end_of_data;
                    frame_done       <= flushing;
                    state            <= w_gap1;
                end

                w_gap1: state <= w_gap2;  // Two quiet cycles between packets
                w_gap2: state <= w_idle;
                default: state <= w_idle;
            endcase
        end
    end

    // Most significant word first
    always_ff @(posedge clk125)
    begin
        if (state == w_idle && start)
        begin
            fifo_bus <= packet[packet_w-1 -: word_w];
            shift_r  <= packet << word_w;
        end
        else if (state == w_send)
        begin
            fifo_bus <= shift_r[packet_w-1 -: word_w];
            shift_r  <= shift_r << word_w;
        end
    end

endmodule

// File: design/xadc_monitor_top.sv
`timescale 1ns/1ps

module xadc_monitor_top
#(
    parameter int max_frame_words = 600
)
(
    input  logic                                   clk125,
    input  logic                                   rst,
    input  logic                                   data_in_rdy,
    input  logic [15:0]                            vmm_id,
    input  logic [xadc_adc_pkg::sample_cnt_w-1:0]  sample_size,
    input  logic [xadc_adc_pkg::delay_w-1:0]       delay_in,
    input  logic                                   udp_done,
    input  logic                                   conv_done,
    input  xadc_adc_pkg::adc_result_t              conv_result,
    output logic                                   xadc_busy,
    output logic                                   conv_start,
    output xadc_adc_pkg::adc_channel_t             adc_channel,
    output xadc_frame_pkg::frame_word_t            fifo_bus,
    output logic                                   data_fifo_enable,
    output xadc_frame_pkg::frame_len_t             packet_len,
    output logic                                   end_of_data
);
    import xadc_adc_pkg::*;
    import xadc_frame_pkg::*;

    logic         save;
    adc_result_t  sample;
    adc_channel_t sample_channel;
    logic         flush;
    logic         frame_done;
    packet_t      packet;
    logic         full;
    frame_len_t   frame_words;
    logic         packet_clear;
    logic         frame_clear;

    xadc_sample_sequencer xadc_sample_sequencer_i
    (
        .clk125         (clk125),
        .rst            (rst),
        .data_in_rdy    (data_in_rdy),
        .vmm_id         (vmm_id),
        .sample_size    (sample_size),
        .delay_in       (delay_in),
        .udp_done       (udp_done),
        .conv_done      (conv_done),
        .conv_result    (conv_result),
        .frame_done     (frame_done),
        .xadc_busy      (xadc_busy),
        .conv_start     (conv_start),
        .adc_channel    (adc_channel),
        .save           (save),
        .sample         (sample),
        .sample_channel (sample_channel),
        .flush          (flush)
    );

    xadc_packet_builder xadc_packet_builder_i
    (
        .clk125         (clk125),
        .rst            (rst),
        .save           (save),
        .sample         (sample),
        .sample_channel (sample_channel),
        .packet_clear   (packet_clear),
        .frame_clear    (frame_clear),
        .packet         (packet),
        .full           (full),
        .frame_words    (frame_words)
    );

    xadc_frame_writer #(
        .max_frame_words (max_frame_words)
    ) xadc_frame_writer_i
    (
        .clk125           (clk125),
        .rst              (rst),
        .full             (full),
        .flush            (flush),
        .packet           (packet),
        .frame_words      (frame_words),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data),
        .packet_clear     (packet_clear),
        .frame_clear      (frame_clear),
        .frame_done       (frame_done)
    );

endmodule

// File: design/xadc_packet_builder.sv
`timescale 1ns/1ps

module xadc_packet_builder
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        save,
    input  xadc_adc_pkg::adc_result_t   sample,
    input  xadc_adc_pkg::adc_channel_t  sample_channel,
    input  logic                        packet_clear,
    input  logic                        frame_clear,
    output xadc_frame_pkg::packet_t     packet,
    output logic                        full,
    output xadc_frame_pkg::frame_len_t  frame_words
);
    import xadc_adc_pkg::*;
    import xadc_frame_pkg::*;

    localparam int slot_w = $clog2(slots_per_packet);

    logic [slot_w-1:0] slot_idx;     // Next free slot
    logic              full_sent;    // Full packet handed over, clear not seen yet
    logic              carry_slot;
    logic              first_slot;
    packet_t           packet_next;

    // A new packet began while the previous full one was still going out
    assign carry_slot = full_sent && (slot_idx != '0);
    assign first_slot = save && (slot_idx == '0);

    // Slot 0 starts a fresh packet so leftovers never leak in
    always_comb
    begin
        packet_next = (slot_idx == '0) ? '0 : packet;
        packet_next[packet_w-1 -: header_w] = {1'b0, sample_channel};
        packet_next[slot_idx*result_w +: result_w] = sample;
    end

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            packet    <= '0;
            slot_idx  <= '0;
            full      <= 1'b0;
            full_sent <= 1'b0;
        end
        else
        begin
            full <= 1'b0;
            if (packet_clear)
                full_sent <= 1'b0;
            if (save)
            begin
                packet <= packet_next;
                if (slot_idx == slot_w'(slots_per_packet - 1))
                begin
                    slot_idx  <= '0;
                    full      <= 1'b1;
                    full_sent <= 1'b1;
                end
                else
                    slot_idx <= slot_idx + 1'b1;
            end
            else if (packet_clear && !carry_slot)
            begin
                packet   <= '0;
                slot_idx <= '0;
            end
        end
    end

    //////////////////////////////
    // Frame length in words
    //////////////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
            frame_words <= '0;
        else if (frame_clear)
            frame_words <= (first_slot || carry_slot) ? len_w'(words_per_packet) : '0;
        else if (first_slot)
            frame_words <= frame_words + len_w'(words_per_packet);  // Counted on first write
    end

endmodule

// File: design/xadc_sample_sequencer.sv
`timescale 1ns/1ps

module xadc_sample_sequencer
(
    input  logic                                   clk125,
    input  logic                                   rst,
    input  logic                                   data_in_rdy,
    input  logic [15:0]                            vmm_id,
    input  logic [xadc_adc_pkg::sample_cnt_w-1:0]  sample_size,
    input  logic [xadc_adc_pkg::delay_w-1:0]       delay_in,
    input  logic                                   udp_done,
    input  logic                                   conv_done,
    input  xadc_adc_pkg::adc_result_t              conv_result,
    input  logic                                   frame_done,
    output logic                                   xadc_busy,
    output logic                                   conv_start,
    output xadc_adc_pkg::adc_channel_t             adc_channel,
    output logic                                   save,
    output xadc_adc_pkg::adc_result_t              sample,
    output xadc_adc_pkg::adc_channel_t             sample_channel,
    output logic                                   flush
);
    import xadc_adc_pkg::*;

    typedef enum logic [2:0]
    {
        s_idle,
        s_start,
        s_wait,
        s_last,
        s_delay,
        s_flush,
        s_release
    } seq_state_t;

    localparam adc_channel_t last_channel = '1;

    seq_state_t              state;
    logic                    read_all;     // Command asked for every chip
    logic [sample_cnt_w-1:0] sample_cnt;
    logic [delay_w-1:0]      delay_cnt;

    //////////////////////////////
    // Command and channel loop
    //////////////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state       <= s_idle;
            xadc_busy   <= 1'b0;
            conv_start  <= 1'b0;
            save        <= 1'b0;
            flush       <= 1'b0;
            read_all    <= 1'b0;
            adc_channel <= '0;
            sample_cnt  <= '0;
            delay_cnt   <= '0;
        end
        else
        begin
            conv_start <= 1'b0;  // Both strobes last one cycle
            save       <= 1'b0;
            case (state)
                s_idle:
                begin
                    if (data_in_rdy)
                    begin
                        xadc_busy   <= 1'b1;
                        read_all    <= (vmm_id[3:0] > 4'd7);
                        adc_channel <= (vmm_id[3:0] > 4'd7) ? '0 : vmm_id[channel_w-1:0];
                        sample_cnt  <= '0;
                        state       <= s_start;
                    end
                end

                s_start:
                begin
                    conv_start <= 1'b1;
                    sample_cnt <= sample_cnt + 1'b1;
                    state      <= s_wait;
                end

                // Converter latency varies, conv_done ends it
                s_wait:
                begin
                    if (conv_done)
                    begin
                        save      <= 1'b1;
                        delay_cnt <= '0;
                        if (sample_cnt >= sample_size)
                            state <= s_last;
                        else
                            state <= s_delay;
                    end
                end

                s_delay:
                begin
                    if (delay_cnt == delay_in)
                        state <= s_start;
                    else
                        delay_cnt <= delay_cnt + 1'b1;
                end

                // One cycle so the builder holds the last result first
                s_last:
                begin
                    flush <= 1'b1;
                    state <= s_flush;
                end

                s_flush:
                begin
                    if (frame_done)
                    begin
                        flush <= 1'b0;
                        if (read_all && adc_channel != last_channel)
                        begin
                            adc_channel <= adc_channel + 1'b1;  // Next chip
                            sample_cnt  <= '0;
                            state       <= s_start;
                        end
                        else
                            state <= s_release;
                    end
                end

                // Old command gone and UDP frame sent
                s_release:
                begin
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= s_idle;
                    end
                end

                default: state <= s_idle;
            endcase
        end
    end

    // Result held for the builder until the next conversion ends
    always_ff @(posedge clk125)
    begin
        if (state == s_wait && conv_done)
        begin
            sample         <= conv_result;
            sample_channel <= adc_channel;
        end
    end

endmodule

// File: list.f
design/xadc_adc_pkg.sv
design/xadc_frame_pkg.sv
design/xadc_sample_sequencer.sv
design/xadc_packet_builder.sv
design/xadc_frame_writer.sv
design/xadc_monitor_top.sv
tb/xadc_monitor_chk.sv
tb/xadc_monitor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the xadc monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module xadc_monitor_tb \
    -f list.f \
    -o xadc_monitor_sim

./obj_dir/xadc_monitor_sim +verilator+error+limit+100 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation passed"

// File: tb/xadc_monitor_chk.sv
`timescale 1ns/1ps

module xadc_monitor_chk
#(
    parameter int max_len = 600
)
(
    input logic                        clk125,
    input logic                        rst,
    input logic                        xadc_busy,
    input logic                        conv_start,
    input logic                        data_fifo_enable,
    input logic                        end_of_data,
    input xadc_frame_pkg::frame_len_t  packet_len
);
    import xadc_frame_pkg::*;

    int         fail_cnt = 0;  // Read by the testbench at the end
    logic [2:0] run_len;       // Length of the current write burst

    always_ff @(posedge clk125)
    begin
        if (rst)
            run_len <= '0;
        else if (data_fifo_enable)
            run_len <= run_len + 1'b1;
        else
            run_len <= '0;
    end

    //////////////////////////////
    // Output protocol
    //////////////////////////////

    burst_max: assert property (@(posedge clk125) disable iff (rst)
        data_fifo_enable |-> run_len < 3'(words_per_packet))
    else
    begin
        fail_cnt++;
        $error("write strobe burst longer than one packet");
    end

    burst_end: assert property (@(posedge clk125) disable iff (rst)
        !data_fifo_enable && run_len != '0 |-> run_len == 3'(words_per_packet))
    else
    begin
        fail_cnt++;
        $error("write strobe burst ended after %0d words", run_len);
    end

    eod_in_burst: assert property (@(posedge clk125) disable iff (rst)
        end_of_data |-> data_fifo_enable)
    else
    begin
        fail_cnt++;
        $error("end_of_data outside a write burst");
    end

    start_in_busy: assert property (@(posedge clk125) disable iff (rst)
        conv_start |-> xadc_busy)
    else
    begin
        fail_cnt++;
        $error("conv_start while not busy");
    end

    // Length counts whole packets only
    len_range: assert property (@(posedge clk125) disable iff (rst)
        packet_len[1:0] == 2'b00 && packet_len <= len_w'(max_len))
    else
    begin
        fail_cnt++;
        $error("packet_len %0d out of range", packet_len);
    end

    after_reset: assert property (@(posedge clk125)
        rst |=> !xadc_busy && !conv_start && !data_fifo_enable && !end_of_data)
    else
    begin
        fail_cnt++;
        $error("control output high after reset");
    end

endmodule

// File: tb/xadc_monitor_tb.sv
`timescale 1ns/1ps

module xadc_monitor_tb;
    import xadc_adc_pkg::*;
    import xadc_frame_pkg::*;

    localparam int frame_limit = 8;
    localparam int wait_limit  = 3000;  // Cycles per wait

    logic                    clk125 = 1'b0;
    logic                    rst;
    logic                    data_in_rdy;
    logic [15:0]             vmm_id;
    logic [sample_cnt_w-1:0] sample_size;
    logic [delay_w-1:0]      delay_in;
    logic                    udp_done;
    logic                    conv_done = 1'b0;
    adc_result_t             conv_result = '0;
    logic                    xadc_busy;
    logic                    conv_start;
    adc_channel_t            adc_channel;
    frame_word_t             fifo_bus;
    logic                    data_fifo_enable;
    frame_len_t              packet_len;
    logic                    end_of_data;

    integer       seed = 32'h627c_8d86;
    string        cur_test = "reset";
    int           errors = 0;
    int           checks = 0;
    int           tests = 0;
    int           test_errors;
    int           total;
    bit           timed_out = 1'b0;
    int           res_base;
    int           pkt_base;

    always #5 clk125 = ~clk125;

    xadc_monitor_top #(.max_frame_words(frame_limit)) xadc_monitor_top_i (.*);

    bind xadc_monitor_top xadc_monitor_chk #(.max_len(max_frame_words)) xadc_monitor_chk_i
    (
        .clk125           (clk125),
        .rst              (rst),
        .xadc_busy        (xadc_busy),
        .conv_start       (conv_start),
        .data_fifo_enable (data_fifo_enable),
        .end_of_data      (end_of_data),
        .packet_len       (packet_len)
    );

    //////////////////////////////
    // Converter model
    //////////////////////////////

    int           model_cnt = 0;
    adc_channel_t model_ch;
    adc_channel_t ch_q[$];
    adc_result_t  res_q[$];

    always @(posedge clk125)
    begin
        #1;
        conv_done = 1'b0;
        if (rst)
            model_cnt = 0;
        else if (model_cnt > 0)
        begin
            model_cnt--;
            if (model_cnt == 0)
            begin
                conv_done   = 1'b1;
                conv_result = adc_result_t'($random(seed));
                ch_q.push_back(model_ch);
                res_q.push_back(conv_result);
            end
        end
        if (conv_start)
        begin
            model_cnt = 1 + int'({$random(seed)} % 32'd8);  // 1 to 8 cycles
            model_ch  = adc_channel;
        end
    end

    // Collector rebuilds packets from the word stream
    logic [63:0] rx_pkt;
    logic [3:0]  eod_bits;
    int          word_n = 0;
    packet_t     pkt_q[$];
    logic [3:0]  eod_q[$];
    frame_len_t  len_q[$];

    always @(posedge clk125)
    begin
        if (!rst && data_fifo_enable)
        begin
            rx_pkt   = {rx_pkt[47:0], fifo_bus};
            eod_bits = {eod_bits[2:0], end_of_data};
            word_n++;
            if (word_n == words_per_packet)
            begin
                pkt_q.push_back(rx_pkt);
                eod_q.push_back(eod_bits);
                len_q.push_back(packet_len);
                word_n = 0;
            end
        end
    end

    // Gap from a result to the next start
    int gap = 0;
    bit gap_armed = 1'b0;

    always @(posedge clk125)
    begin
        if (rst || !xadc_busy)
            gap_armed = 1'b0;
        else if (conv_done)
        begin
            gap       = 0;
            gap_armed = 1'b1;
        end
        else if (gap_armed)
        begin
            gap++;
            if (conv_start)
            begin
                gap_armed = 1'b0;
                assert (gap >= int'(delay_in) + 1)
                else
                begin
                    $display("[FAIL] %s start gap expected at least %0d actual %0d",
                             cur_test, int'(delay_in) + 1, gap);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    //////////////////////////////
    // Checks and waits
    //////////////////////////////

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (!timed_out && xadc_busy !== level)
        begin
            @(posedge clk125);
            #1;
            n++;
            if (n == wait_limit)
            begin
                $display("%s: timeout, xadc_busy never went to %0b", cur_test, level);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_packets(input int count);
        int n;
        n = 0;
        while (!timed_out && pkt_q.size() < count)
        begin
            @(posedge clk125);
            #1;
            n++;
            if (n == wait_limit)
            begin
                $display("%s: timeout, only %0d packets arrived", cur_test, pkt_q.size());
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic hold_busy(input int cycles, input string what);
        int n;
        for (n = 0; n < cycles; n++)
        begin
            @(posedge clk125);
            #1;
            check_value(what, 64'd1, 64'(xadc_busy));
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        res_base    = res_q.size();
        pkt_base    = pkt_q.size();
    endtask

    task automatic issue_command(input logic [15:0] id, input int size, input int gap_cycles);
        vmm_id      = id;
        sample_size = sample_cnt_w'(size);
        delay_in    = delay_w'(gap_cycles);
        data_in_rdy = 1'b1;
        @(posedge clk125);
        #1;
    endtask

    // Expected packets from the recorded results
    task automatic check_output(input int runs, input int size, input int first_ch);
        packet_t exp_pkt;
        int      frame_cnt;
        int      k;
        int      r;
        int      s;
        int      slot;
        int      idx;
        int      ch;
        bit      last;
        if (timed_out)
            return;
        frame_cnt = 0;
        k         = pkt_base;
        check_value("conversions", 64'(runs * size), 64'(res_q.size() - res_base));
        if (res_q.size() - res_base != runs * size)
            return;
        for (r = 0; r < runs; r++)
        begin
            ch = first_ch + r;
            for (s = 0; s < size; s += slots_per_packet)
            begin
                exp_pkt = '0;  // Empty slots stay zero
                exp_pkt[packet_w-1 -: header_w] = {1'b0, ch[channel_w-1:0]};
                for (slot = 0; slot < slots_per_packet && s + slot < size; slot++)
                begin
                    idx = res_base + r * size + s + slot;
                    check_value("channel", 64'(ch), 64'(ch_q[idx]));
                    exp_pkt[slot*result_w +: result_w] = res_q[idx];
                end
                last      = (s + slots_per_packet >= size);
                frame_cnt = frame_cnt + words_per_packet;
                if (k < pkt_q.size())
                begin
                    check_value("packet", exp_pkt, pkt_q[k]);
                    check_value("packet_len", 64'(frame_cnt), 64'(len_q[k]));
                    check_value("end_of_data", (last || frame_cnt == frame_limit) ? 64'd1 : 64'd0,
                                64'(eod_q[k]));
                end
                if (last || frame_cnt == frame_limit)
                    frame_cnt = 0;  // New frame
                k++;
            end
        end
        check_value("packets", 64'(k - pkt_base), 64'(pkt_q.size() - pkt_base));
    endtask

    task automatic finish_test();
        tests++;
        $display("%s: %0d packets, %0d errors", cur_test, pkt_q.size() - pkt_base, test_errors);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        rst         = 1'b1;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b1;
        repeat (5) @(posedge clk125);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk125);
        #1;

        start_test("single_channel");
        issue_command(16'd5, 7, 3);
        data_in_rdy = 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_output(1, 7, 5);
        finish_test();

        start_test("read_all");
        issue_command(16'd15, 2, 3);  // Above 7 reads every chip
        data_in_rdy = 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_output(8, 2, 0);
        finish_test();

        start_test("length_limit");
        issue_command(16'd3, 15, 2);
        data_in_rdy = 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_output(1, 15, 3);
        finish_test();

        // Release needs the command gone and the UDP sender done
        start_test("delay_and_busy");
        udp_done = 1'b0;
        issue_command(16'd6, 3, 20);
        wait_busy(1'b1);
        wait_packets(pkt_base + 1);
        udp_done = 1'b1;
        hold_busy(5, "busy while data_in_rdy high");
        data_in_rdy = 1'b0;
        udp_done    = 1'b0;
        hold_busy(20, "busy while udp_done low");
        udp_done = 1'b1;
        wait_busy(1'b0);
        check_output(1, 3, 6);
        finish_test();

        repeat (4) @(posedge clk125);
        total = errors + xadc_monitor_top_i.xadc_monitor_chk_i.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, total);
        if (timed_out || total != 0)
            $display("ERRORS FOUND");
        else
            $display("NO ERRORS");
        $finish;
    end

endmodule
